//--- include/hsk_defines.svh
`ifndef HSK_DEFINES_SVH
`define HSK_DEFINES_SVH

// clocking and serial rate
`define HSK_CLK_HZ   100000000
`define HSK_BAUD     1000000
`define HSK_ACC_BITS 10

// rounded accumulator step for a 16x baud strobe, 164 at 100 MHz and 1 Mbaud
`define HSK_ACC_STEP ((64'd32 * `HSK_BAUD * (64'd1 << `HSK_ACC_BITS) / `HSK_CLK_HZ + 64'd1) / 64'd2)

// link identity
`define HSK_MY_ADDR  8'h40
`define HSK_ID_WORD  32'h4853_4B31
`define HSK_MAX_LEN  16

// command codes
`define HSK_CMD_PING     8'h00
`define HSK_CMD_IDENTIFY 8'h12

`endif

//--- src/hsk_pkg.sv
`default_nettype none

`include "hsk_defines.svh"

package hsk_pkg;

    typedef logic [7:0] hsk_byte_t;
    typedef logic [7:0] hsk_addr_t;
    typedef logic [7:0] hsk_cmd_t;
    // payload length, wide enough for HSK_MAX_LEN
    typedef logic [4:0] hsk_len_t;
    // extra top bit is the carry that makes the baud strobe
    typedef logic [`HSK_ACC_BITS:0] hsk_acc_t;

    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

    typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;

    typedef enum logic [2:0] {
        rs_collect,
        rs_check,
        rs_encode,
        rs_send,
        rs_wait
    } resp_state_e;

endpackage

`default_nettype wire

//--- src/hsk_byte_if.sv
`timescale 1ns/1ns
`default_nettype none

// decoded packet bytes, no back-pressure
interface hsk_byte_if;
    import hsk_pkg::*;

    hsk_byte_t data;
    logic      valid;
    logic      last;
    logic      err;

    modport driver (output data, output valid, output last, output err);

    modport sink (input data, input valid, input last, input err);

endinterface

`default_nettype wire

//--- src/hsk_baud_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "hsk_defines.svh"

module hsk_baud_gen (
    input  logic clk,
    input  logic arst_n_i,
    output logic tick_o
);
    import hsk_pkg::*;

    localparam hsk_acc_t step = hsk_acc_t'(`HSK_ACC_STEP);

    hsk_acc_t acc_q;

    // the carry is dropped on the next add, so it lasts one cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q <= '0;
        end else begin
            acc_q <= {1'b0, acc_q[`HSK_ACC_BITS-1:0]} + step;
        end
    end

    assign tick_o = acc_q[`HSK_ACC_BITS];

endmodule

`default_nettype wire

//--- src/hsk_uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module hsk_uart_rx (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               tick_i,
    input  logic               serial_i,
    output hsk_pkg::hsk_byte_t data_o,
    output logic               valid_o,
    output logic               frame_err_o
);
    import hsk_pkg::*;

    rx_state_e  state_q;
    logic [1:0] sync_q;
    logic       prev_q;
    logic [3:0] cnt_q;
    logic [2:0] bit_q;
    hsk_byte_t  shift_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= rx_idle;
            sync_q      <= 2'b11;
            prev_q      <= 1'b1;
            cnt_q       <= '0;
            bit_q       <= '0;
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            sync_q      <= {sync_q[0], serial_i};
            prev_q      <= sync_q[1];
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
            case (state_q)
                rx_idle: begin
                    // falling edge only, a held-low line does not restart
                    if (prev_q && !sync_q[1]) begin
                        cnt_q   <= '0;
                        state_q <= rx_start;
                    end
                end
                rx_start: begin
                    if (tick_i) begin
                        cnt_q <= cnt_q + 4'd1;
                        // middle of the start bit, reject glitches
                        if (cnt_q == 4'd7) begin
                            cnt_q   <= '0;
                            bit_q   <= '0;
                            state_q <= sync_q[1] ? rx_idle : rx_data;
                        end
                    end
                end
                rx_data: begin
                    if (tick_i) begin
                        cnt_q <= cnt_q + 4'd1;
                        if (cnt_q == 4'd15) begin
                            bit_q <= bit_q + 3'd1;
                            if (bit_q == 3'd7) begin
                                state_q <= rx_stop;
                            end
                        end
                    end
                end
                default: begin
                    if (tick_i) begin
                        cnt_q <= cnt_q + 4'd1;
                        if (cnt_q == 4'd15) begin
                            valid_o     <= sync_q[1];
                            frame_err_o <= !sync_q[1];
                            state_q     <= rx_idle;
                        end
                    end
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state_q == rx_data && tick_i && cnt_q == 4'd15) begin
            shift_q <= {sync_q[1], shift_q[7:1]};
        end
    end

    assign data_o = shift_q;

endmodule

`default_nettype wire

//--- src/hsk_uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module hsk_uart_tx (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               tick_i,
    input  hsk_pkg::hsk_byte_t data_i,
    input  logic               start_i,
    output logic               serial_o,
    output logic               busy_o
);
    import hsk_pkg::*;

    tx_state_e  state_q;
    logic       pend_q;
    logic       serial_q;
    logic [3:0] cnt_q;
    logic [2:0] bit_q;
    hsk_byte_t  shift_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= tx_idle;
            pend_q   <= 1'b0;
            serial_q <= 1'b1;
            cnt_q    <= '0;
            bit_q    <= '0;
        end else begin
            case (state_q)
                tx_idle: begin
                    if (start_i) begin
                        pend_q <= 1'b1;
                    end
                    // start bit begins on a tick so every bit is 16 ticks
                    if (pend_q && tick_i) begin
                        pend_q   <= 1'b0;
                        serial_q <= 1'b0;
                        cnt_q    <= '0;
                        state_q  <= tx_start;
                    end
                end
                tx_start: begin
                    if (tick_i) begin
                        cnt_q <= cnt_q + 4'd1;
                        if (cnt_q == 4'd15) begin
                            serial_q <= shift_q[0];
                            bit_q    <= '0;
                            state_q  <= tx_data;
                        end
                    end
                end
                tx_data: begin
                    if (tick_i) begin
                        cnt_q <= cnt_q + 4'd1;
                        if (cnt_q == 4'd15) begin
                            bit_q <= bit_q + 3'd1;
                            if (bit_q == 3'd7) begin
                                serial_q <= 1'b1;
                                state_q  <= tx_stop;
                            end else begin
                                serial_q <= shift_q[1];
                            end
                        end
                    end
                end
                default: begin
                    if (tick_i) begin
                        cnt_q <= cnt_q + 4'd1;
                        if (cnt_q == 4'd15) begin
                            state_q <= tx_idle;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == tx_idle && start_i) begin
            shift_q <= data_i;
        end else if (state_q == tx_data && tick_i && cnt_q == 4'd15) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign serial_o = serial_q;
    assign busy_o   = pend_q || (state_q != tx_idle);

endmodule

`default_nettype wire

//--- src/hsk_cobs_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module hsk_cobs_decoder (
    input  logic               clk,
    input  logic               arst_n_i,
    input  hsk_pkg::hsk_byte_t rx_data_i,
    input  logic               rx_valid_i,
    input  logic               rx_frame_err_i,
    hsk_byte_if.driver         pkt
);
    import hsk_pkg::*;

    // data bytes left in the current block, zero means a code byte is due
    hsk_byte_t cnt_q;
    hsk_byte_t code_q;
    logic      in_pkt_q;
    // one byte is held back so that last can go with the final byte
    hsk_byte_t pend_q;
    logic      pend_v_q;
    logic      zero_due;

    // a block shorter than FF ends in an implied zero, unless the packet ends
    assign zero_due = in_pkt_q && (code_q != 8'hFF);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q     <= '0;
            code_q    <= 8'hFF;
            in_pkt_q  <= 1'b0;
            pend_v_q  <= 1'b0;
            pkt.valid <= 1'b0;
            pkt.last  <= 1'b0;
            pkt.err   <= 1'b0;
        end else begin
            pkt.valid <= 1'b0;
            pkt.last  <= 1'b0;
            pkt.err   <= 1'b0;
            if (rx_frame_err_i) begin
                pkt.err  <= 1'b1;
                cnt_q    <= '0;
                code_q   <= 8'hFF;
                in_pkt_q <= 1'b0;
                pend_v_q <= 1'b0;
            end else if (rx_valid_i) begin
                if (rx_data_i == 8'h00) begin
                    // delimiter is only good at a block boundary of a nonempty packet
                    if (in_pkt_q && cnt_q == 8'h00 && pend_v_q) begin
                        pkt.valid <= 1'b1;
                        pkt.last  <= 1'b1;
                    end else begin
                        pkt.err <= 1'b1;
                    end
                    cnt_q    <= '0;
                    code_q   <= 8'hFF;
                    in_pkt_q <= 1'b0;
                    pend_v_q <= 1'b0;
                end else if (cnt_q == 8'h00) begin
                    if (zero_due) begin
                        pkt.valid <= pend_v_q;
                        pend_v_q  <= 1'b1;
                    end
                    code_q   <= rx_data_i;
                    cnt_q    <= rx_data_i - 8'd1;
                    in_pkt_q <= 1'b1;
                end else begin
                    pkt.valid <= pend_v_q;
                    pend_v_q  <= 1'b1;
                    cnt_q     <= cnt_q - 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid_i) begin
            pkt.data <= pend_q;
            if (cnt_q != 8'h00) begin
                pend_q <= rx_data_i;
            end else if (zero_due) begin
                pend_q <= 8'h00;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/hsk_responder.sv
`timescale 1ns/1ns
`default_nettype none

`include "hsk_defines.svh"

module hsk_responder (
    input  logic               clk,
    input  logic               arst_n_i,
    hsk_byte_if.sink           pkt,
    input  logic               tx_busy_i,
    output hsk_pkg::hsk_byte_t tx_data_o,
    output logic               tx_start_o
);
    import hsk_pkg::*;

    // header of four, payload, checksum
    localparam logic [4:0]  buf_len = 5'(`HSK_MAX_LEN + 5);
    localparam logic [31:0] id_word = `HSK_ID_WORD;
    localparam hsk_byte_t   id_csum = 8'h00 - (`HSK_CMD_IDENTIFY + 8'd4 + id_word[31:24]
                                      + id_word[23:16] + id_word[15:8] + id_word[7:0]);

    resp_state_e state_q;
    hsk_byte_t   buf_q [buf_len];
    hsk_byte_t   sum_q;
    logic [4:0]  idx_q;
    logic        ovf_q;
    logic [4:0]  pos_q;
    logic [4:0]  scan_q;
    logic        code_q;
    logic        fin_q;

    hsk_addr_t   dst;
    hsk_cmd_t    cmd;
    hsk_len_t    plen;
    logic        len_ok;
    logic        pass;

    assign dst  = buf_q[1];
    assign cmd  = buf_q[2];
    assign plen = buf_q[3][4:0];

    // bytes received must be the length field plus five
    assign len_ok = !ovf_q && (idx_q >= 5'd5) && (buf_q[3][7:5] == 3'b000)
                    && (idx_q == plen + 5'd5);
    assign pass   = (dst == `HSK_MY_ADDR) && len_ok && (sum_q == 8'h00)
                    && (cmd == `HSK_CMD_PING || cmd == `HSK_CMD_IDENTIFY);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= rs_collect;
            sum_q   <= '0;
            idx_q   <= '0;
            ovf_q   <= 1'b0;
            pos_q   <= '0;
            scan_q  <= '0;
            code_q  <= 1'b0;
            fin_q   <= 1'b0;
        end else begin
            case (state_q)
                rs_collect: begin
                    if (pkt.err) begin
                        idx_q <= '0;
                        sum_q <= '0;
                        ovf_q <= 1'b0;
                    end else if (pkt.valid) begin
                        // checksum covers everything after the addresses
                        if (idx_q >= 5'd2) begin
                            sum_q <= sum_q + pkt.data;
                        end
                        if (idx_q == buf_len) begin
                            ovf_q <= 1'b1;
                        end else begin
                            idx_q <= idx_q + 5'd1;
                        end
                        if (pkt.last) begin
                            state_q <= rs_check;
                        end
                    end
                end
                rs_check: begin
                    sum_q <= '0;
                    ovf_q <= 1'b0;
                    if (pass) begin
                        pos_q   <= '0;
                        scan_q  <= '0;
                        state_q <= rs_encode;
                        if (cmd == `HSK_CMD_IDENTIFY) begin
                            idx_q <= 5'd9;
                        end
                    end else begin
                        idx_q   <= '0;
                        state_q <= rs_collect;
                    end
                end
                rs_encode: begin
                    // look ahead for the zero or the end that closes this block
                    if (scan_q == idx_q || buf_q[scan_q] == 8'h00) begin
                        code_q  <= 1'b1;
                        state_q <= rs_send;
                    end else begin
                        scan_q <= scan_q + 5'd1;
                    end
                end
                rs_send: begin
                    if (!tx_busy_i) begin
                        state_q <= rs_wait;
                        if (code_q) begin
                            code_q <= 1'b0;
                        end else if (!fin_q) begin
                            pos_q <= pos_q + 5'd1;
                        end
                    end
                end
                default: begin
                    if (!tx_busy_i) begin
                        if (fin_q) begin
                            fin_q   <= 1'b0;
                            idx_q   <= '0;
                            state_q <= rs_collect;
                        end else if (pos_q != scan_q) begin
                            state_q <= rs_send;
                        end else if (scan_q == idx_q) begin
                            fin_q   <= 1'b1;
                            state_q <= rs_send;
                        end else begin
                            // skip the zero, it is carried by the code byte
                            pos_q   <= scan_q + 5'd1;
                            scan_q  <= scan_q + 5'd1;
                            state_q <= rs_encode;
                        end
                    end
                end
            endcase
        end
    end

    // a ping reply keeps its checksum since only the addresses change
    always_ff @(posedge clk) begin
        if (state_q == rs_collect && pkt.valid && !pkt.err && idx_q < buf_len) begin
            buf_q[idx_q] <= pkt.data;
        end else if (state_q == rs_check && pass) begin
            buf_q[0] <= `HSK_MY_ADDR;
            buf_q[1] <= buf_q[0];
            if (cmd == `HSK_CMD_IDENTIFY) begin
                buf_q[3] <= 8'd4;
                buf_q[4] <= id_word[31:24];
                buf_q[5] <= id_word[23:16];
                buf_q[6] <= id_word[15:8];
                buf_q[7] <= id_word[7:0];
                buf_q[8] <= id_csum;
            end
        end
    end

    always_comb begin
        if (fin_q) begin
            tx_data_o = 8'h00;
        end else if (code_q) begin
            tx_data_o = {3'b000, scan_q - pos_q} + 8'd1;
        end else begin
            tx_data_o = buf_q[pos_q];
        end
    end

    assign tx_start_o = (state_q == rs_send) && !tx_busy_i;

endmodule

`default_nettype wire

//--- src/hsk_top.sv
`timescale 1ns/1ns
`default_nettype none

module hsk_top (
    input  logic clk,
    input  logic arst_n_i,
    input  logic uart_rx_i,
    output logic uart_tx_o
);
    import hsk_pkg::*;

    logic      tick;
    hsk_byte_t rx_data;
    logic      rx_valid;
    logic      rx_frame_err;
    hsk_byte_t tx_data;
    logic      tx_start;
    logic      tx_busy;

    hsk_byte_if pkt_if ();

    hsk_baud_gen u_baud_gen (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .tick_o   (tick)
    );

    hsk_uart_rx u_uart_rx (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .tick_i      (tick),
        .serial_i    (uart_rx_i),
        .data_o      (rx_data),
        .valid_o     (rx_valid),
        .frame_err_o (rx_frame_err)
    );

    hsk_cobs_decoder u_cobs_decoder (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .rx_data_i      (rx_data),
        .rx_valid_i     (rx_valid),
        .rx_frame_err_i (rx_frame_err),
        .pkt            (pkt_if.driver)
    );

    hsk_responder u_responder (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .pkt        (pkt_if.sink),
        .tx_busy_i  (tx_busy),
        .tx_data_o  (tx_data),
        .tx_start_o (tx_start)
    );

    hsk_uart_tx u_uart_tx (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .tick_i   (tick),
        .data_i   (tx_data),
        .start_i  (tx_start),
        .serial_o (uart_tx_o),
        .busy_o   (tx_busy)
    );

endmodule

`default_nettype wire

//--- dv/hsk_properties.sv
`timescale 1ns/1ns
`default_nettype none

`include "hsk_defines.svh"

module hsk_properties (
    input logic clk,
    input logic arst_n_i,
    input logic tx_line_i
);
    localparam int bit_cycles = `HSK_CLK_HZ / `HSK_BAUD;

    // consecutive cycles with the line low
    logic [15:0] low_cnt_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            low_cnt_q <= '0;
        end else if (!tx_line_i) begin
            low_cnt_q <= low_cnt_q + 16'd1;
        end else begin
            low_cnt_q <= '0;
        end
    end

    tx_idle_in_reset: assert property (@(posedge clk) !arst_n_i |-> tx_line_i)
        else $error("uart_tx_o is low while reset is asserted");

    // a low run is made of whole bits and may not end early
    // the tx bit is 16 ticks and can be a cycle or so under the nominal period
    start_bit_length: assert property (@(posedge clk) disable iff (!arst_n_i)
        (tx_line_i && low_cnt_q != 16'd0) |-> low_cnt_q >= 16'(bit_cycles - 2))
        else $error("low level on uart_tx_o shorter than one bit period");

    tx_low_limit: assert property (@(posedge clk) disable iff (!arst_n_i)
        low_cnt_q <= 16'(10 * bit_cycles))
        else $error("uart_tx_o held low for more than ten bit periods");

endmodule

bind hsk_top hsk_properties u_properties (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .tx_line_i (uart_tx_o)
);

`default_nettype wire

//--- dv/hsk_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "hsk_defines.svh"

module hsk_tb;
    import hsk_pkg::*;

    localparam int bit_cycles     = `HSK_CLK_HZ / `HSK_BAUD;
    localparam int byte_cycles    = 10 * bit_cycles;
    // longest packet or reply on the wire with COBS overhead and delimiter
    localparam int frame_bytes    = `HSK_MAX_LEN + 7;
    localparam int reply_wait     = frame_bytes * byte_cycles;
    // ten full replies cover the roughly 150 byte times of the run
    localparam int timeout_cycles = 10 * frame_bytes * byte_cycles;
    localparam logic [31:0] id_word = `HSK_ID_WORD;
    localparam hsk_addr_t host_addr = 8'h07;

    logic clk = 1'b0;
    logic arst_n_i;
    logic uart_rx_i;
    logic uart_tx_o;

    logic reset_done = 1'b0;
    int   seed = 32'haaa0;
    int   errors = 0;
    int   tests = 0;
    int   cycle_cnt = 0;
    int   byte_cnt = 0;
    int   reply_cnt = 0;

    hsk_byte_t pay_q[$];
    hsk_byte_t pkt_q[$];
    hsk_byte_t enc_q[$];
    hsk_byte_t exp_q[$];
    // raw bytes from uart_tx_o up to the delimiter
    hsk_byte_t frame_q[$];
    hsk_byte_t reply_q[$];

    hsk_top uut (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .uart_rx_i (uart_rx_i),
        .uart_tx_o (uart_tx_o)
    );

    always #5 clk = ~clk;

    task automatic log_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err0);
        tests++;
        $display("test %s: %s", name, (errors == err0) ? "passed" : "failed");
    endtask

    task automatic send_byte(input hsk_byte_t b, input logic stop_bit);
        int i;
        uart_rx_i = 1'b0;
        repeat (bit_cycles) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            uart_rx_i = b[i];
            repeat (bit_cycles) @(negedge clk);
        end
        uart_rx_i = stop_bit;
        repeat (bit_cycles) @(negedge clk);
        // after a low stop bit the line must go high before the next start edge
        if (!stop_bit) begin
            uart_rx_i = 1'b1;
            repeat (bit_cycles) @(negedge clk);
        end
        uart_rx_i = 1'b1;
    endtask

    task automatic random_payload(input int n);
        logic [31:0] rnd;
        int i;
        pay_q.delete();
        for (i = 0; i < n; i++) begin
            rnd = $random(seed);
            if (rnd[7:0] == 8'h00) begin
                rnd[7:0] = 8'hA5;
            end
            pay_q.push_back(rnd[7:0]);
        end
    endtask

    task automatic build_packet(input hsk_addr_t src, input hsk_addr_t dst, input hsk_cmd_t cmd,
                                input logic bad_sum);
        hsk_byte_t sum;
        int i;
        pkt_q.delete();
        pkt_q.push_back(src);
        pkt_q.push_back(dst);
        pkt_q.push_back(cmd);
        pkt_q.push_back(hsk_byte_t'(pay_q.size()));
        sum = cmd + hsk_byte_t'(pay_q.size());
        for (i = 0; i < pay_q.size(); i++) begin
            pkt_q.push_back(pay_q[i]);
            sum = sum + pay_q[i];
        end
        // checksum brings command, length and payload to zero mod 256
        pkt_q.push_back((8'h00 - sum) ^ {7'd0, bad_sum});
    endtask

    task automatic build_expected(input hsk_addr_t src, input hsk_cmd_t cmd);
        hsk_byte_t sum;
        int i;
        exp_q.delete();
        exp_q.push_back(`HSK_MY_ADDR);
        exp_q.push_back(src);
        exp_q.push_back(cmd);
        if (cmd == `HSK_CMD_IDENTIFY) begin
            exp_q.push_back(8'd4);
            for (i = 3; i >= 0; i--) begin
                exp_q.push_back(id_word[8*i +: 8]);
            end
        end else begin
            exp_q.push_back(hsk_byte_t'(pay_q.size()));
            for (i = 0; i < pay_q.size(); i++) begin
                exp_q.push_back(pay_q[i]);
            end
        end
        sum = 8'h00;
        for (i = 2; i < exp_q.size(); i++) begin
            sum = sum + exp_q[i];
        end
        exp_q.push_back(8'h00 - sum);
    endtask

    // packets stay far below 254 bytes so no block is ever split at FF
    task automatic cobs_encode();
        int code_pos;
        int i;
        hsk_byte_t code;
        enc_q.delete();
        code_pos = 0;
        enc_q.push_back(8'h00);
        code = 8'h01;
        for (i = 0; i < pkt_q.size(); i++) begin
            if (pkt_q[i] == 8'h00) begin
                enc_q[code_pos] = code;
                code_pos = enc_q.size();
                enc_q.push_back(8'h00);
                code = 8'h01;
            end else begin
                enc_q.push_back(pkt_q[i]);
                code = code + 8'h01;
            end
        end
        enc_q[code_pos] = code;
    endtask

    task automatic cobs_decode();
        int i;
        int j;
        int code;
        reply_q.delete();
        i = 0;
        while (i < frame_q.size()) begin
            code = int'(frame_q[i]);
            i++;
            for (j = 1; j < code && i < frame_q.size(); j++) begin
                reply_q.push_back(frame_q[i]);
                i++;
            end
            // implied zero between blocks but none after the final one
            if (code < 255 && i < frame_q.size()) begin
                reply_q.push_back(8'h00);
            end
        end
        frame_q.delete();
    endtask

    task automatic send_frame();
        int i;
        for (i = 0; i < enc_q.size(); i++) begin
            send_byte(enc_q[i], 1'b1);
        end
        send_byte(8'h00, 1'b1);
    endtask

    task automatic expect_silence(input int nbytes);
        int n;
        logic quiet;
        quiet = 1'b1;
        for (n = 0; n < nbytes * byte_cycles; n++) begin
            @(negedge clk);
            if (!uart_tx_o) begin
                quiet = 1'b0;
            end
        end
        assert (quiet) else log_error("uart_tx_o left idle where no reply is due");
    endtask

    task automatic check_reply();
        hsk_byte_t sum;
        int i;
        assert (reply_q.size() == exp_q.size())
            else log_error($sformatf("reply has %0d bytes, expected %0d",
                                     reply_q.size(), exp_q.size()));
        for (i = 0; i < exp_q.size() && i < reply_q.size(); i++) begin
            assert (reply_q[i] == exp_q[i])
                else log_error($sformatf("reply byte %0d is %h, expected %h",
                                         i, reply_q[i], exp_q[i]));
        end
        sum = 8'h00;
        for (i = 2; i < reply_q.size(); i++) begin
            sum = sum + reply_q[i];
        end
        assert (sum == 8'h00) else log_error("reply checksum does not sum to zero");
    endtask

    task automatic exchange(input string name, input hsk_addr_t dst, input hsk_cmd_t cmd,
                            input logic bad_sum, input logic answered);
        int err0;
        int n0;
        int waited;
        err0 = errors;
        n0 = reply_cnt;
        build_packet(host_addr, dst, cmd, bad_sum);
        cobs_encode();
        send_frame();
        if (answered) begin
            build_expected(host_addr, cmd);
            waited = 0;
            while (reply_cnt == n0 && waited < reply_wait) begin
                @(negedge clk);
                waited++;
            end
            assert (reply_cnt != n0)
                else log_error($sformatf("no reply within %0d cycles", reply_wait));
            if (reply_cnt != n0) begin
                check_reply();
            end
        end else begin
            // a reply would be as long as the packet
            expect_silence(enc_q.size() + 1);
        end
        finish_test(name, err0);
    endtask

    // serial monitor sampling uart_tx_o at mid-bit
    initial begin : tx_monitor
        hsk_byte_t b;
        int i;
        wait (reset_done);
        forever begin
            @(negedge clk);
            if (!uart_tx_o) begin
                repeat (bit_cycles / 2) @(negedge clk);
                assert (!uart_tx_o) else log_error("start bit on uart_tx_o too short");
                for (i = 0; i < 8; i++) begin
                    repeat (bit_cycles) @(negedge clk);
                    b[i] = uart_tx_o;
                end
                repeat (bit_cycles) @(negedge clk);
                assert (uart_tx_o) else log_error("stop bit on uart_tx_o is low");
                byte_cnt++;
                if (b == 8'h00) begin
                    cobs_decode();
                    reply_cnt++;
                end else begin
                    frame_q.push_back(b);
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : stimulus
        int err0;
        int i;
        uart_rx_i = 1'b1;
        arst_n_i  = 1'b1;
        // reset goes low on the first falling edge
        @(negedge clk);
        arst_n_i = 1'b0;
        repeat (4) @(negedge clk);
        arst_n_i   = 1'b1;
        reset_done = 1'b1;

        err0 = errors;
        expect_silence(2);
        assert (byte_cnt == 0) else log_error("bytes seen on uart_tx_o before any stimulus");
        finish_test("idle after reset", err0);

        random_payload(4);
        exchange("ping", `HSK_MY_ADDR, `HSK_CMD_PING, 1'b0, 1'b1);

        pay_q.delete();
        exchange("identify", `HSK_MY_ADDR, `HSK_CMD_IDENTIFY, 1'b0, 1'b1);

        random_payload(5);
        pay_q[0] = 8'h00;
        pay_q[1] = 8'h00;
        pay_q[3] = 8'h00;
        exchange("ping with zero bytes", `HSK_MY_ADDR, `HSK_CMD_PING, 1'b0, 1'b1);

        random_payload(4);
        exchange("ping to other address", 8'h41, `HSK_CMD_PING, 1'b0, 1'b0);
        exchange("ping with bad checksum", `HSK_MY_ADDR, `HSK_CMD_PING, 1'b1, 1'b0);

        // whole packet with an extra byte that has a low stop bit
        // the bytes after the abort are too few to form a packet
        err0 = errors;
        random_payload(4);
        build_packet(host_addr, `HSK_MY_ADDR, `HSK_CMD_PING, 1'b0);
        cobs_encode();
        for (i = 0; i < enc_q.size(); i++) begin
            if (i == 7) begin
                send_byte(8'h5A, 1'b0);
            end
            send_byte(enc_q[i], 1'b1);
        end
        send_byte(8'h00, 1'b1);
        expect_silence(enc_q.size() + 1);
        finish_test("framing error", err0);

        random_payload(4);
        exchange("ping after framing error", `HSK_MY_ADDR, `HSK_CMD_PING, 1'b0, 1'b1);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
src/hsk_pkg.sv
src/hsk_byte_if.sv
src/hsk_baud_gen.sv
src/hsk_uart_rx.sv
src/hsk_uart_tx.sv
src/hsk_cobs_decoder.sv
src/hsk_responder.sv
src/hsk_top.sv
dv/hsk_properties.sv
dv/hsk_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, the log decides the result
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module hsk_tb -o hsk_sim \
    && ./obj_dir/hsk_sim 2>&1 | tee sim.log \
    && grep -q "Simulation finished: PASS" sim.log \
    && ! grep -q "Simulation finished: FAIL" sim.log \
    && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }
